//--- Bender.yml
package:
  name: i3c_target

sources:
  - include_dirs:
      - common
    files:
      - common/i3c_target_pkg.sv
      - source/addr_matcher.sv
      - source/write_path.sv
      - fsm/target_fsm.sv
      - source/i3c_target_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/i3c_target_checker.sv
      - sim/tb_i3c_target.sv

//--- common/i3c_target_cfg.svh
/*
 * Width and address constants of the I3C target core
 * Bus byte width, target address width and the broadcast byte
 */
`ifndef I3C_TARGET_CFG_SVH
`define I3C_TARGET_CFG_SVH

// Width of one bus byte
`define I3C_BYTE_W 8

// Width of a 7-bit target address
`define I3C_ADDR_W 7

// Broadcast address 7'h7E followed by the write bit
`define I3C_BCAST_BYTE 8'hFC

`endif

//--- common/i3c_target_pkg.sv
/*
 * Shared types of the I3C target core
 * Primary FSM state encoding and packed bus, config and match structs
 */
`include "i3c_target_cfg.svh"

package i3c_target_pkg;

  // Primary transfer states
  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait
  } state_e;

  // Strobes from the bus monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_det_t;

  // Requests to the receive engine
  typedef struct packed {
    logic req_byte;
    logic req_bit;
  } bus_rx_req_t;

  // Receive engine answer, data valid with done
  typedef struct packed {
    logic                   done;
    logic [`I3C_BYTE_W-1:0] data;
  } bus_rx_rsp_t;

  // Requests to the transmit engine, bit transfers use value[0]
  typedef struct packed {
    logic                   req_byte;
    logic                   req_bit;
    logic [`I3C_BYTE_W-1:0] value;
  } bus_tx_req_t;

  // Static and dynamic target addresses
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] sta_addr;
    logic                   sta_valid;
    logic [`I3C_ADDR_W-1:0] dyn_addr;
    logic                   dyn_valid;
  } addr_cfg_t;

  // Decoded address byte
  typedef struct packed {
    logic own;
    logic bcast;
    logic rnw;
  } match_t;

endpackage

//--- compile.f
+incdir+common
common/i3c_target_pkg.sv
source/addr_matcher.sv
source/write_path.sv
fsm/target_fsm.sv
source/i3c_target_top.sv
sim/i3c_target_checker.sv
sim/tb_i3c_target.sv

//--- fsm/target_fsm.sv
/*
 * Primary transfer FSM of the I3C target
 * Address phase, broadcast second byte, private write and read loops
 * Bus engine requests are decoded from the current state
 */
`timescale 1ns/100ps
`include "i3c_target_cfg.svh"

module target_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        target_enable_i,
  input  i3c_target_pkg::bus_det_t    bus_det_i,
  input  logic                        bus_rx_done_i,
  input  logic                        bus_tx_done_i,
  input  logic                        tx_fifo_rvalid_i,
  input  logic [`I3C_BYTE_W-1:0]      tx_fifo_rdata_i,
  input  i3c_target_pkg::match_t      match_i,
  output i3c_target_pkg::bus_rx_req_t bus_rx_req_o,
  output i3c_target_pkg::bus_tx_req_t bus_tx_req_o,
  output logic                        addr_load_o,
  output logic                        idle_o,
  output logic                        wr_enter_o,
  output logic                        tbit_done_o,
  output logic                        wr_leave_o,
  output logic                        tx_fifo_rready_o,
  output logic                        event_target_nack_o,
  output logic                        target_transmitting_o
);

  i3c_target_pkg::state_e state_q, state_d;

  // Start and repeated start are handled alike
  logic start;
  assign start = bus_det_i.start | bus_det_i.rstart;

  // Byte popped from the TX FIFO, sent in TxPReadData
  logic [`I3C_BYTE_W-1:0] tx_byte_q;

  // Set while in Wait, turns the NACK event into a pulse
  logic in_wait;
  logic nack_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      i3c_target_pkg::Idle: begin
        if (target_enable_i && start) begin
          state_d = i3c_target_pkg::RxFByte;
        end
      end
      i3c_target_pkg::RxFByte: begin
        if (bus_rx_done_i) begin
          state_d = i3c_target_pkg::CheckFByte;
        end
      end
      // Own address or broadcast gets an ACK
      i3c_target_pkg::CheckFByte: begin
        if (match_i.own || match_i.bcast) begin
          state_d = i3c_target_pkg::TxAckFByte;
        end else begin
          state_d = i3c_target_pkg::Wait;
        end
      end
      i3c_target_pkg::TxAckFByte: begin
        if (bus_tx_done_i) begin
          if (match_i.bcast) begin
            state_d = i3c_target_pkg::RxSByte;
          end else if (match_i.rnw) begin
            // Empty TX FIFO, nothing to send
            state_d = tx_fifo_rvalid_i ? i3c_target_pkg::TxPReadData : i3c_target_pkg::Wait;
          end else begin
            state_d = i3c_target_pkg::RxPWriteData;
          end
        end
      end
      // After broadcast only a repeated start is followed here
      i3c_target_pkg::RxSByte: begin
        if (start) begin
          state_d = i3c_target_pkg::RxSByteRepeated;
        end else if (bus_det_i.stop) begin
          state_d = i3c_target_pkg::Idle;
        end else if (bus_rx_done_i) begin
          state_d = i3c_target_pkg::Wait;
        end
      end
      i3c_target_pkg::RxSByteRepeated: begin
        if (bus_rx_done_i) begin
          state_d = i3c_target_pkg::CheckSByte;
        end
      end
      i3c_target_pkg::CheckSByte: begin
        state_d = match_i.own ? i3c_target_pkg::TxAckSByte : i3c_target_pkg::Wait;
      end
      i3c_target_pkg::TxAckSByte: begin
        if (bus_tx_done_i) begin
          if (!match_i.rnw) begin
            state_d = i3c_target_pkg::RxPWriteData;
          end else if (tx_fifo_rvalid_i) begin
            state_d = i3c_target_pkg::TxPReadData;
          end else begin
            state_d = i3c_target_pkg::Wait;
          end
        end
      end
      // Private write loop
      i3c_target_pkg::RxPWriteData: begin
        if (start) begin
          state_d = i3c_target_pkg::RxFByte;
        end else if (bus_det_i.stop) begin
          state_d = i3c_target_pkg::Idle;
        end else if (bus_rx_done_i) begin
          state_d = i3c_target_pkg::RxPWriteTbit;
        end
      end
      i3c_target_pkg::RxPWriteTbit: begin
        if (bus_rx_done_i) begin
          state_d = i3c_target_pkg::RxPWriteData;
        end
      end
      // Private read loop
      i3c_target_pkg::TxPReadData: begin
        if (start) begin
          state_d = i3c_target_pkg::RxFByte;
        end else if (bus_det_i.stop) begin
          state_d = i3c_target_pkg::Idle;
        end else if (bus_tx_done_i) begin
          state_d = i3c_target_pkg::TxPReadTbit;
        end
      end
      i3c_target_pkg::TxPReadTbit: begin
        if (bus_tx_done_i) begin
          state_d = tx_fifo_rvalid_i ? i3c_target_pkg::TxPReadData : i3c_target_pkg::Wait;
        end
      end
      // Not ours, hold off until repeated start or stop
      i3c_target_pkg::Wait: begin
        if (start) begin
          state_d = i3c_target_pkg::RxFByte;
        end else if (bus_det_i.stop) begin
          state_d = i3c_target_pkg::Idle;
        end
      end
      default: begin
        state_d = i3c_target_pkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_target_pkg::Idle;
      nack_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      nack_q  <= in_wait;
    end
  end

  // Holds the popped byte for the whole byte transfer
  always_ff @(posedge clk_i) begin
    if (tx_fifo_rready_o) begin
      tx_byte_q <= tx_fifo_rdata_i;
    end
  end

  // Bus requests, ACK is a bit of 0 and read T-bit a bit of 1
  always_comb begin
    bus_rx_req_o = '0;
    bus_tx_req_o = '0;
    case (state_q)
      i3c_target_pkg::RxFByte,
      i3c_target_pkg::RxSByte,
      i3c_target_pkg::RxSByteRepeated,
      i3c_target_pkg::RxPWriteData: bus_rx_req_o.req_byte = 1'b1;
      i3c_target_pkg::RxPWriteTbit: bus_rx_req_o.req_bit = 1'b1;
      i3c_target_pkg::TxAckFByte,
      i3c_target_pkg::TxAckSByte: bus_tx_req_o.req_bit = 1'b1;
      i3c_target_pkg::TxPReadData: begin
        bus_tx_req_o.req_byte = 1'b1;
        bus_tx_req_o.value    = tx_byte_q;
      end
      i3c_target_pkg::TxPReadTbit: begin
        bus_tx_req_o.req_bit  = 1'b1;
        bus_tx_req_o.value[0] = 1'b1;
      end
      default: ;
    endcase
  end

  // Address byte done in one of the address states
  assign addr_load_o = bus_rx_done_i & (state_q inside {i3c_target_pkg::RxFByte,
                                                        i3c_target_pkg::RxSByte,
                                                        i3c_target_pkg::RxSByteRepeated});

  // Write loop markers
  assign wr_enter_o  = (state_d == i3c_target_pkg::RxPWriteData) &
                       (state_q != i3c_target_pkg::RxPWriteData);
  assign tbit_done_o = (state_q == i3c_target_pkg::RxPWriteTbit) & bus_rx_done_i;
  assign wr_leave_o  = (state_q == i3c_target_pkg::RxPWriteData) & (start | bus_det_i.stop);

  // Pop one byte per TxPReadData entry
  assign tx_fifo_rready_o = (state_d == i3c_target_pkg::TxPReadData) &
                            (state_q != i3c_target_pkg::TxPReadData);

  assign in_wait             = (state_q == i3c_target_pkg::Wait);
  assign event_target_nack_o = in_wait & ~nack_q;

  assign idle_o = (state_q == i3c_target_pkg::Idle);
  assign target_transmitting_o = state_q inside {i3c_target_pkg::TxAckFByte,
                                                 i3c_target_pkg::TxAckSByte,
                                                 i3c_target_pkg::TxPReadData,
                                                 i3c_target_pkg::TxPReadTbit};

endmodule

//--- sim/i3c_target_checker.sv
/*
 * Concurrent assertions on the I3C target top level
 * FIFO strobe width, request exclusivity, parity versus FIFO write
 */
`timescale 1ns/100ps

module i3c_target_checker (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        idle_i,
  input logic                        tx_fifo_rready_i,
  input logic                        rx_fifo_wvalid_i,
  input logic                        parity_err_i,
  input i3c_target_pkg::bus_rx_req_t rx_req_i,
  input i3c_target_pkg::bus_tx_req_t tx_req_i
);

  // Any request pending per engine
  logic rx_busy;
  logic tx_busy;

  // Parity error seen in this transfer, dropped in idle
  logic par_seen_q;

  assign rx_busy = rx_req_i.req_byte | rx_req_i.req_bit;
  assign tx_busy = tx_req_i.req_byte | tx_req_i.req_bit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      par_seen_q <= 1'b0;
    end else if (parity_err_i) begin
      par_seen_q <= 1'b1;
    end else if (idle_i) begin
      par_seen_q <= 1'b0;
    end
  end

  rready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_fifo_rready_i |=> !tx_fifo_rready_i)
    else $error("tx_fifo_rready_o high for more than one cycle");

  wvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_fifo_wvalid_i |=> !rx_fifo_wvalid_i)
    else $error("rx_fifo_wvalid_o high for more than one cycle");

  // One engine at a time on the bus
  req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_busy && tx_busy))
    else $error("RX and TX requests high together");

  // No write in the error cycle or later in the same transfer
  wvalid_no_parity: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_fifo_wvalid_i && (parity_err_i || par_seen_q)))
    else $error("RX FIFO written with a parity error");

endmodule

bind i3c_target_top i3c_target_checker i_i3c_target_checker (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .idle_i           (target_idle_o),
  .tx_fifo_rready_i (tx_fifo_rready_o),
  .rx_fifo_wvalid_i (rx_fifo_wvalid_o),
  .parity_err_i     (parity_err_o),
  .rx_req_i         (bus_rx_req_o),
  .tx_req_i         (bus_tx_req_o)
);

//--- sim/tb_i3c_target.sv
/*
 * Testbench of the I3C target core
 * Bus engine and TX FIFO models, transfer table, monitor and watchdog
 */
`timescale 1ns/100ps
`include "i3c_target_cfg.svh"

module tb_i3c_target;

  localparam int CLK_PERIOD = 100;
  localparam int N_ROWS     = 7;

  // Transfer kinds
  localparam logic [1:0] MODE_WR = 2'd0;
  localparam logic [1:0] MODE_RD = 2'd1;
  localparam logic [1:0] MODE_BC = 2'd2;

  // Static 7'h2A only, or static 7'h2A plus dynamic 7'h11
  localparam i3c_target_pkg::addr_cfg_t CFG_STA  = {7'h2A, 1'b1, 7'h00, 1'b0};
  localparam i3c_target_pkg::addr_cfg_t CFG_BOTH = {7'h2A, 1'b1, 7'h11, 1'b1};

  localparam i3c_target_pkg::bus_det_t DET_START  = 3'b100;
  localparam i3c_target_pkg::bus_det_t DET_RSTART = 3'b010;
  localparam i3c_target_pkg::bus_det_t DET_STOP   = 3'b001;

  // One transfer, data byte i sits in data[8*i +: 8]
  typedef struct packed {
    logic [1:0]                mode;
    i3c_target_pkg::addr_cfg_t cfg;
    logic [6:0]                addr;
    logic [2:0]                n;
    logic [31:0]               data;
    logic                      corrupt;
    logic                      wready;
    logic                      exp_ack;
    logic [2:0]                exp_wr;
    logic                      exp_par;
    logic                      exp_ovf;
    logic                      exp_nack;
    logic                      exp_last;
  } row_t;

  row_t rows [N_ROWS];

  logic                        clk_i;
  logic                        rst_ni;
  logic                        target_enable_i;
  i3c_target_pkg::addr_cfg_t   addr_cfg_i;
  i3c_target_pkg::bus_det_t    bus_det_i;
  i3c_target_pkg::bus_rx_rsp_t bus_rx_rsp_i;
  logic                        bus_tx_done_i;
  logic                        tx_fifo_rvalid_i;
  logic [`I3C_BYTE_W-1:0]      tx_fifo_rdata_i;
  logic                        rx_fifo_wready_i;
  i3c_target_pkg::bus_rx_req_t bus_rx_req_o;
  i3c_target_pkg::bus_tx_req_t bus_tx_req_o;
  logic                        tx_fifo_rready_o;
  logic                        rx_fifo_wvalid_o;
  logic [`I3C_BYTE_W-1:0]      rx_fifo_wdata_o;
  logic                        rx_last_byte_o;
  logic                        parity_err_o;
  logic                        rx_overflow_err_o;
  logic                        event_target_nack_o;
  logic                        target_idle_o;
  logic                        target_transmitting_o;

  // TX FIFO model contents
  logic [`I3C_BYTE_W-1:0] tx_mem [0:7];
  int                     tx_len;
  int                     rd_ptr;
  logic                   pop;

  // Monitor results of the current row
  int                     par_cnt;
  int                     ovf_cnt;
  int                     nack_cnt;
  int                     last_cnt;
  int                     pop_cnt;
  logic [`I3C_BYTE_W-1:0] wr_q [$];

  logic [7:0] lfsr_q;

  i3c_target_top i_i3c_target_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  assign tx_fifo_rvalid_i = (rd_ptr < tx_len);
  assign tx_fifo_rdata_i  = tx_mem[rd_ptr];

  // Pop seen mid cycle, applied after the next edge
  always begin
    @(negedge clk_i);
    pop = tx_fifo_rready_o;
    @(posedge clk_i);
    #10;
    if (pop) begin
      rd_ptr = rd_ptr + 1;
    end
  end

  // Outputs are sampled mid cycle where they are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rx_fifo_wvalid_o) begin
        wr_q.push_back(rx_fifo_wdata_o);
      end
      if (parity_err_o) par_cnt++;
      if (rx_overflow_err_o) ovf_cnt++;
      if (event_target_nack_o) nack_cnt++;
      if (rx_last_byte_o) last_cnt++;
      if (tx_fifo_rready_o) pop_cnt++;
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Inputs change 10 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  // Engine answer delay of 1 to 4 cycles, two LFSR bits
  task automatic draw_delay(output int k);
    k = 1;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      if (lfsr_q[0]) k = k + (1 << b);
    end
  endtask

  task automatic pulse_det(input i3c_target_pkg::bus_det_t d);
    bus_det_i = d;
    step();
    bus_det_i = '0;
  endtask

  // Receive engine, done and data for one cycle
  task automatic answer_rx(input logic is_bit, input logic [`I3C_BYTE_W-1:0] d);
    int k;
    while (!(is_bit ? bus_rx_req_o.req_bit : bus_rx_req_o.req_byte)) step();
    draw_delay(k);
    repeat (k) step();
    bus_rx_rsp_i = {1'b1, d};
    step();
    bus_rx_rsp_i = '0;
  endtask

  // Transmit engine, checks kind and value of the request
  task automatic answer_tx(input logic is_bit, input logic [`I3C_BYTE_W-1:0] exp_val);
    int k;
    while (!(bus_tx_req_o.req_bit || bus_tx_req_o.req_byte)) step();
    check_value("bus_tx_req_o.req_byte", bus_tx_req_o.req_byte, !is_bit);
    check_value("bus_tx_req_o.value", bus_tx_req_o.value, exp_val);
    draw_delay(k);
    for (int j = 0; j < k; j++) begin
      check_value("target_transmitting_o", target_transmitting_o, 1);
      step();
    end
    bus_tx_done_i = 1'b1;
    step();
    bus_tx_done_i = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    logic [`I3C_BYTE_W-1:0] d;
    logic                   tbit;
    addr_cfg_i       = r.cfg;
    rx_fifo_wready_i = r.wready;
    for (int i = 0; i < 4; i++) begin
      tx_mem[i] = r.data[8*i +: 8];
    end
    rd_ptr   = 0;
    tx_len   = (r.mode == MODE_RD) ? r.n : 0;
    par_cnt  = 0;
    ovf_cnt  = 0;
    nack_cnt = 0;
    last_cnt = 0;
    pop_cnt  = 0;
    wr_q.delete();
    pulse_det(DET_START);
    // Broadcast first, then repeated start in the second byte phase
    if (r.mode == MODE_BC) begin
      answer_rx(1'b0, `I3C_BCAST_BYTE);
      answer_tx(1'b1, 8'h00);
      while (!bus_rx_req_o.req_byte) step();
      pulse_det(DET_RSTART);
    end
    answer_rx(1'b0, {r.addr, r.mode == MODE_RD});
    if (!r.exp_ack) begin
      // No ACK may be driven on the way to Wait
      while (nack_cnt == 0) begin
        check_value("bus_tx_req_o.req_bit", bus_tx_req_o.req_bit, 0);
        step();
      end
    end else begin
      answer_tx(1'b1, 8'h00);
      if (r.mode == MODE_RD) begin
        for (int i = 0; i < r.n; i++) begin
          answer_tx(1'b0, r.data[8*i +: 8]);
          answer_tx(1'b1, 8'h01);
        end
        // Empty TX FIFO ends the read in Wait
        while (nack_cnt == 0) step();
      end else begin
        for (int i = 0; i < r.n; i++) begin
          d    = r.data[8*i +: 8];
          // T-bit makes the count of ones in byte and T-bit odd
          tbit = ($countones(d) % 2 == 0);
          // Second byte gets the bad T-bit, later bytes stay blocked
          if (r.corrupt && i == 1) tbit = ~tbit;
          answer_rx(1'b0, d);
          answer_rx(1'b1, {7'b0, tbit});
        end
        while (!bus_rx_req_o.req_byte) step();
      end
    end
    pulse_det(DET_STOP);
    while (!target_idle_o) step();
    check_value("parity_err_o pulses", par_cnt, r.exp_par);
    check_value("rx_overflow_err_o pulses", ovf_cnt, r.exp_ovf);
    check_value("event_target_nack_o pulses", nack_cnt, r.exp_nack);
    check_value("rx_last_byte_o pulses", last_cnt, r.exp_last);
    check_value("tx_fifo_rready_o pulses", pop_cnt, (tx_len != 0 && r.exp_ack) ? r.n : 0);
    check_value("rx_fifo_wvalid_o pulses", wr_q.size(), r.exp_wr);
    for (int i = 0; i < r.exp_wr; i++) begin
      check_value("rx_fifo_wdata_o", wr_q[i], r.data[8*i +: 8]);
    end
  endtask

  // Watchdog sized from the table length
  initial begin
    #(N_ROWS * 400 * CLK_PERIOD);
    $display("Timeout: the transfers did not finish in time");
    $display("sim failed");
    $fatal(1);
  end

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    target_enable_i  = 1'b1;
    addr_cfg_i       = '0;
    bus_det_i        = '0;
    bus_rx_rsp_i     = '0;
    bus_tx_done_i    = 1'b0;
    rx_fifo_wready_i = 1'b1;
    tx_len           = 0;
    rd_ptr           = 0;
    pop              = 1'b0;
    lfsr_q           = 8'd20;
    for (int i = 0; i < 8; i++) begin
      tx_mem[i] = '0;
    end
    // mode cfg addr n data corrupt wready ack wr par ovf nack last
    rows[0] = '{MODE_WR, CFG_STA, 7'h2A, 3, 32'h00013CA5, 0, 1, 1, 3, 0, 0, 0, 1};
    rows[1] = '{MODE_WR, CFG_STA, 7'h2A, 3, 32'h00C3775A, 1, 1, 1, 1, 1, 0, 0, 1};
    rows[2] = '{MODE_RD, CFG_STA, 7'h2A, 3, 32'h00FF10C3, 0, 1, 1, 0, 0, 0, 1, 0};
    rows[3] = '{MODE_WR, CFG_BOTH, 7'h2A, 1, 32'h00000055, 0, 1, 0, 0, 0, 0, 1, 0};
    rows[4] = '{MODE_WR, CFG_BOTH, 7'h11, 2, 32'h00008001, 0, 1, 1, 2, 0, 0, 0, 1};
    rows[5] = '{MODE_WR, CFG_BOTH, 7'h11, 2, 32'h00006633, 0, 0, 1, 0, 0, 1, 0, 1};
    rows[6] = '{MODE_BC, CFG_BOTH, 7'h11, 2, 32'h0000429E, 0, 1, 1, 2, 0, 0, 0, 1};
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    // Quiet outputs after reset
    check_value("target_idle_o", target_idle_o, 1);
    check_value("target_transmitting_o", target_transmitting_o, 0);
    check_value("bus_rx_req_o", bus_rx_req_o, 0);
    check_value("bus_tx_req_o", bus_tx_req_o, 0);
    check_value("tx_fifo_rready_o", tx_fifo_rready_o, 0);
    check_value("rx_fifo_wvalid_o", rx_fifo_wvalid_o, 0);
    check_value("rx_last_byte_o", rx_last_byte_o, 0);
    check_value("parity_err_o", parity_err_o, 0);
    check_value("rx_overflow_err_o", rx_overflow_err_o, 0);
    check_value("event_target_nack_o", event_target_nack_o, 0);
    for (int r_idx = 0; r_idx < N_ROWS; r_idx++) begin
      run_row(rows[r_idx]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- source/addr_matcher.sv
/*
 * Address byte latch and match logic
 * Dynamic address before static address, plus broadcast decode
 */
`timescale 1ns/100ps
`include "i3c_target_cfg.svh"

module addr_matcher (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      addr_load_i,
  input  logic                      idle_i,
  input  logic [`I3C_BYTE_W-1:0]    rx_data_i,
  input  i3c_target_pkg::addr_cfg_t addr_cfg_i,
  output i3c_target_pkg::match_t    match_o
);

  // Latched address and read/not-write bit
  logic [`I3C_ADDR_W-1:0] addr_q;
  logic                   rnw_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (addr_load_i) begin
      addr_q <= rx_data_i[`I3C_BYTE_W-1:1];
      rnw_q  <= rx_data_i[0];
    end else if (idle_i) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  always_comb begin
    // A valid dynamic address hides the static one
    if (addr_cfg_i.dyn_valid) begin
      match_o.own = (addr_cfg_i.dyn_addr == addr_q);
    end else if (addr_cfg_i.sta_valid) begin
      match_o.own = (addr_cfg_i.sta_addr == addr_q);
    end else begin
      match_o.own = 1'b0;
    end
    // Broadcast is 7'h7E with write only
    match_o.bcast = ({addr_q, rnw_q} == `I3C_BCAST_BYTE);
    match_o.rnw   = rnw_q;
  end

endmodule

//--- source/i3c_target_top.sv
/*
 * Transfer-level core of an I3C target
 * Connects the primary FSM, the address matcher and the write path
 */
`timescale 1ns/100ps
`include "i3c_target_cfg.svh"

module i3c_target_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        target_enable_i,
  input  i3c_target_pkg::addr_cfg_t   addr_cfg_i,
  input  i3c_target_pkg::bus_det_t    bus_det_i,
  input  i3c_target_pkg::bus_rx_rsp_t bus_rx_rsp_i,
  input  logic                        bus_tx_done_i,
  input  logic                        tx_fifo_rvalid_i,
  input  logic [`I3C_BYTE_W-1:0]      tx_fifo_rdata_i,
  input  logic                        rx_fifo_wready_i,
  output i3c_target_pkg::bus_rx_req_t bus_rx_req_o,
  output i3c_target_pkg::bus_tx_req_t bus_tx_req_o,
  output logic                        tx_fifo_rready_o,
  output logic                        rx_fifo_wvalid_o,
  output logic [`I3C_BYTE_W-1:0]      rx_fifo_wdata_o,
  output logic                        rx_last_byte_o,
  output logic                        parity_err_o,
  output logic                        rx_overflow_err_o,
  output logic                        event_target_nack_o,
  output logic                        target_idle_o,
  output logic                        target_transmitting_o
);

  // Address byte completion and decode result
  logic                   addr_load;
  i3c_target_pkg::match_t match;

  // Write loop markers towards the write path
  logic wr_enter;
  logic tbit_done;
  logic wr_leave;

  // Primary state machine, its idle flag also clears the side blocks
  target_fsm i_target_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (target_enable_i),
    .bus_det_i             (bus_det_i),
    .bus_rx_done_i         (bus_rx_rsp_i.done),
    .bus_tx_done_i         (bus_tx_done_i),
    .tx_fifo_rvalid_i      (tx_fifo_rvalid_i),
    .tx_fifo_rdata_i       (tx_fifo_rdata_i),
    .match_i               (match),
    .bus_rx_req_o          (bus_rx_req_o),
    .bus_tx_req_o          (bus_tx_req_o),
    .addr_load_o           (addr_load),
    .idle_o                (target_idle_o),
    .wr_enter_o            (wr_enter),
    .tbit_done_o           (tbit_done),
    .wr_leave_o            (wr_leave),
    .tx_fifo_rready_o      (tx_fifo_rready_o),
    .event_target_nack_o   (event_target_nack_o),
    .target_transmitting_o (target_transmitting_o)
  );

  addr_matcher i_addr_matcher (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_load_i (addr_load),
    .idle_i      (target_idle_o),
    .rx_data_i   (bus_rx_rsp_i.data),
    .addr_cfg_i  (addr_cfg_i),
    .match_o     (match)
  );

  // Start and repeated start both reset the overflow block
  write_path i_write_path (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_req_byte_i     (bus_rx_req_o.req_byte),
    .rx_rsp_i          (bus_rx_rsp_i),
    .idle_i            (target_idle_o),
    .start_i           (bus_det_i.start | bus_det_i.rstart),
    .wr_enter_i        (wr_enter),
    .tbit_done_i       (tbit_done),
    .wr_leave_i        (wr_leave),
    .rx_fifo_wready_i  (rx_fifo_wready_i),
    .rx_fifo_wvalid_o  (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o   (rx_fifo_wdata_o),
    .rx_last_byte_o    (rx_last_byte_o),
    .parity_err_o      (parity_err_o),
    .rx_overflow_err_o (rx_overflow_err_o)
  );

endmodule

//--- source/write_path.sv
/*
 * Private write data path
 * Received byte register, odd parity check, error latches, RX FIFO strobes
 */
`timescale 1ns/100ps
`include "i3c_target_cfg.svh"

module write_path (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rx_req_byte_i,
  input  i3c_target_pkg::bus_rx_rsp_t rx_rsp_i,
  input  logic                        idle_i,
  input  logic                        start_i,
  input  logic                        wr_enter_i,
  input  logic                        tbit_done_i,
  input  logic                        wr_leave_i,
  input  logic                        rx_fifo_wready_i,
  output logic                        rx_fifo_wvalid_o,
  output logic [`I3C_BYTE_W-1:0]      rx_fifo_wdata_o,
  output logic                        rx_last_byte_o,
  output logic                        parity_err_o,
  output logic                        rx_overflow_err_o
);

  // Last completed byte on the bus
  logic [`I3C_BYTE_W-1:0] byte_q;

  // Expected T-bit and mismatch in the T-bit cycle
  logic exp_tbit;
  logic parity_fail;

  // Sticky errors
  logic parity_err_q;
  logic ovf_q;
  // Delayed overflow flag for the edge pulse
  logic ovf_d_q;

  always_ff @(posedge clk_i) begin
    if (rx_req_byte_i && rx_rsp_i.done) begin
      byte_q <= rx_rsp_i.data;
    end
  end

  // Odd parity over byte and T-bit
  assign exp_tbit    = ~^byte_q;
  assign parity_fail = tbit_done_i & (rx_rsp_i.data[0] != exp_tbit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parity_err_q <= 1'b0;
    end else if (parity_fail) begin
      parity_err_q <= 1'b1;
    end else if (idle_i) begin
      parity_err_q <= 1'b0;
    end
  end

  // FIFO full when a byte is about to be received
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ovf_q   <= 1'b0;
      ovf_d_q <= 1'b0;
    end else begin
      ovf_d_q <= ovf_q;
      if (wr_enter_i && !rx_fifo_wready_i) begin
        ovf_q <= 1'b1;
      end else if (idle_i || start_i) begin
        ovf_q <= 1'b0;
      end
    end
  end

  assign parity_err_o      = parity_fail;
  assign rx_overflow_err_o = ovf_q & ~ovf_d_q;

  // Checked bytes only, nothing while an error is held
  assign rx_fifo_wvalid_o = tbit_done_i & ~parity_fail & ~parity_err_q & ~ovf_q;
  assign rx_fifo_wdata_o  = byte_q;

  // Write loop closed by start or stop
  assign rx_last_byte_o = wr_leave_i;

endmodule
